// File: db_nwr_sequencer.sv
/* Self-check and NWRITE transaction FSM; both requests need link_up_i in idle.
   Status and error outputs are registered, one cycle after the decoder or timer pulse. */
`timescale 1ns/1ps
module db_nwr_sequencer (
    input  logic                   log_clk,
    input  logic                   log_rst,
    input  logic                   link_up_i,
    input  logic                   self_check_i,
    input  logic                   nwr_req_i,
    input  logic                   req_done_i,
    input  logic                   resp_ready_i,
    input  logic                   resp_busy_i,
    input  logic                   resp_confirm_i,
    input  logic                   time_out_i,
    output srio_db_pkg::req_kind_e req_kind_o,
    output logic                   txn_id_o,
    output logic [15:0]            expected_info_o,
    output logic                   wait_en_o,
    output logic                   nwr_ready_o,
    output logic                   nwr_busy_o,
    output logic                   nwr_done_ack_o,
    output logic                   error_o,
    output srio_db_pkg::err_type_e error_type_o
);
    import srio_db_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SELF_DB,
        S_SELF_WAIT,
        S_NWR,
        S_INTEG_DB,
        S_INTEG_WAIT
    } state_e;

    state_e state;

    assign wait_en_o       = (state == S_SELF_WAIT) || (state == S_INTEG_WAIT);
    assign expected_info_o = integ_db_info(txn_id_o);

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            state          <= S_IDLE;
            req_kind_o     <= REQ_NONE;
            txn_id_o       <= 1'b0;
            nwr_ready_o    <= 1'b0;
            nwr_busy_o     <= 1'b0;
            nwr_done_ack_o <= 1'b0;
            error_o        <= 1'b0;
            error_type_o   <= ERR_NONE;
        end else begin
            nwr_done_ack_o <= 1'b0;
            error_o        <= 1'b0;
            error_type_o   <= ERR_NONE;
            case (state)
                S_IDLE: begin
                    if (link_up_i && self_check_i) begin
                        state       <= S_SELF_DB;
                        req_kind_o  <= REQ_SELF_DB;
                        nwr_ready_o <= 1'b0;
                        nwr_busy_o  <= 1'b0;
                    end else if (link_up_i && nwr_req_i) begin
                        state      <= S_NWR;
                        req_kind_o <= REQ_NWR;
                    end
                end
                S_SELF_DB: begin
                    if (req_done_i) begin
                        state      <= S_SELF_WAIT;
                        req_kind_o <= REQ_NONE;
                    end
                end
                S_SELF_WAIT: begin
                    if (resp_ready_i) begin
                        state       <= S_IDLE;
                        nwr_ready_o <= 1'b1;
                    end else if (resp_busy_i) begin
                        state      <= S_IDLE;
                        nwr_busy_o <= 1'b1;
                    end else if (time_out_i) begin
                        state        <= S_IDLE;
                        error_o      <= 1'b1;
                        error_type_o <= ERR_DB_NO_RESP;
                    end
                end
                S_NWR: begin
                    if (req_done_i) begin
                        state      <= S_INTEG_DB;
                        req_kind_o <= REQ_NONE;
                    end
                end
                S_INTEG_DB: begin
                    // One idle cycle of REQ_NONE re-arms the builder
                    if (req_done_i) begin
                        state      <= S_INTEG_WAIT;
                        req_kind_o <= REQ_NONE;
                    end else if (req_kind_o == REQ_NONE) begin
                        req_kind_o <= REQ_INTEG_DB;
                    end
                end
                S_INTEG_WAIT: begin
                    if (resp_confirm_i) begin
                        state          <= S_IDLE;
                        nwr_done_ack_o <= 1'b1;
                        txn_id_o       <= !txn_id_o;
                    end else if (time_out_i) begin
                        state        <= S_IDLE;
                        error_o      <= 1'b1;
                        error_type_o <= ERR_INTEG_NO_RESP;
                    end
                end
                default: begin
                    state      <= S_IDLE;
                    req_kind_o <= REQ_NONE;
                end
            endcase
        end
    end

endmodule

// File: db_req_assert.sv
/* Bound into db_req_top. Checks the request stream handshake and the status outputs,
   all disabled while log_rst is high. */
`timescale 1ns/1ps
module db_req_assert (
    input logic        log_clk,
    input logic        log_rst,
    input logic        req_valid_i,
    input logic        req_ready_i,
    input logic        req_last_i,
    input logic [63:0] req_data_i,
    input logic [7:0]  req_keep_i,
    input logic [31:0] req_user_i,
    input logic        error_i,
    input logic [1:0]  error_type_i,
    input logic        ready_i,
    input logic        busy_i
);

    // A stalled beat stays valid and unchanged
    a_req_beat_held: assert property (@(posedge log_clk) disable iff (log_rst)
        (req_valid_i && !req_ready_i) |=>
        (req_valid_i && $stable({req_last_i, req_data_i, req_keep_i, req_user_i})))
        else $error("Request beat changed or dropped while tready was low");

    a_err_type: assert property (@(posedge log_clk) disable iff (log_rst)
        error_i == (error_type_i != 2'd0))
        else $error("error_type_o does not match error_o");

    a_status_excl: assert property (@(posedge log_clk) disable iff (log_rst)
        !(ready_i && busy_i))
        else $error("nwr_ready_o and nwr_busy_o high together");

endmodule

bind db_req_top db_req_assert u_db_req_assert (
    .log_clk      (log_clk),
    .log_rst      (log_rst),
    .req_valid_i  (ireq_tvalid_o),
    .req_ready_i  (ireq_tready_i),
    .req_last_i   (ireq_tlast_o),
    .req_data_i   (ireq_tdata_o),
    .req_keep_i   (ireq_tkeep_o),
    .req_user_i   (ireq_tuser_o),
    .error_i      (error_o),
    .error_type_i (error_type_o),
    .ready_i      (nwr_ready_o),
    .busy_i       (nwr_busy_o)
);

// File: db_req_top.sv
/* Request side of the doorbell/NWRITE initiator; responses are always accepted.
   User first beats carry the size byte (bytes minus one) on user_tsize_i. */
`timescale 1ns/1ps
module db_req_top (
    input  logic                           log_clk,
    input  logic                           log_rst,
    input  logic [15:0]                    src_id_i,
    input  logic [15:0]                    dest_id_i,
    input  logic                           link_up_i,
    input  logic                           self_check_i,
    input  logic                           nwr_req_i,
    input  logic                           user_tvalid_i,
    output logic                           user_tready_o,
    input  logic                           user_tfirst_i,
    input  logic                           user_tlast_i,
    input  srio_db_pkg::beat_t             user_tdata_i,
    input  logic [srio_db_pkg::KEEP_W-1:0] user_tkeep_i,
    input  logic [7:0]                     user_tsize_i,
    output logic                           ireq_tvalid_o,
    input  logic                           ireq_tready_i,
    output logic                           ireq_tlast_o,
    output srio_db_pkg::beat_t             ireq_tdata_o,
    output logic [srio_db_pkg::KEEP_W-1:0] ireq_tkeep_o,
    output logic [srio_db_pkg::USER_W-1:0] ireq_tuser_o,
    input  logic                           iresp_tvalid_i,
    output logic                           iresp_tready_o,
    input  srio_db_pkg::beat_t             iresp_tdata_i,
    input  logic [srio_db_pkg::USER_W-1:0] iresp_tuser_i,
    output logic                           nwr_ready_o,
    output logic                           nwr_busy_o,
    output logic                           nwr_done_ack_o,
    output logic                           error_o,
    output srio_db_pkg::err_type_e         error_type_o
);
    import srio_db_pkg::*;

    beat_t             fifo_wr_data;
    logic              head_valid;
    logic              head_first;
    logic              head_last;
    logic [KEEP_W-1:0] head_keep;
    beat_t             head_data;
    logic              fifo_pop;
    req_kind_e         req_kind;
    logic              txn_id;
    logic              req_done;
    logic [15:0]       expected_info;
    logic              resp_ready;
    logic              resp_busy;
    logic              resp_confirm;
    logic              wait_en;
    logic              time_out;

    assign iresp_tready_o = 1'b1;
    // Size byte replaces the data of a first beat
    assign fifo_wr_data   = user_tfirst_i ? {{(DATA_W-8){1'b0}}, user_tsize_i} : user_tdata_i;

    user_beat_fifo u_user_beat_fifo (
        .log_clk      (log_clk),
        .log_rst      (log_rst),
        .wr_valid_i   (user_tvalid_i),
        .wr_first_i   (user_tfirst_i),
        .wr_last_i    (user_tlast_i),
        .wr_keep_i    (user_tkeep_i),
        .wr_data_i    (fifo_wr_data),
        .pop_i        (fifo_pop),
        .wr_ready_o   (user_tready_o),
        .head_valid_o (head_valid),
        .head_first_o (head_first),
        .head_last_o  (head_last),
        .head_keep_o  (head_keep),
        .head_data_o  (head_data)
    );

    resp_decoder u_resp_decoder (
        .log_clk         (log_clk),
        .log_rst         (log_rst),
        .iresp_tvalid_i  (iresp_tvalid_i),
        .iresp_tdata_i   (iresp_tdata_i),
        .iresp_tuser_i   (iresp_tuser_i),
        .expected_info_i (expected_info),
        .resp_ready_o    (resp_ready),
        .resp_busy_o     (resp_busy),
        .resp_confirm_o  (resp_confirm)
    );

    resp_timer u_resp_timer (
        .log_clk    (log_clk),
        .log_rst    (log_rst),
        .wait_en_i  (wait_en),
        .time_out_o (time_out)
    );

    req_beat_builder u_req_beat_builder (
        .log_clk       (log_clk),
        .log_rst       (log_rst),
        .req_kind_i    (req_kind),
        .txn_id_i      (txn_id),
        .src_id_i      (src_id_i),
        .dest_id_i     (dest_id_i),
        .head_valid_i  (head_valid),
        .head_first_i  (head_first),
        .head_last_i   (head_last),
        .head_keep_i   (head_keep),
        .head_data_i   (head_data),
        .ireq_tready_i (ireq_tready_i),
        .fifo_pop_o    (fifo_pop),
        .req_done_o    (req_done),
        .ireq_tvalid_o (ireq_tvalid_o),
        .ireq_tlast_o  (ireq_tlast_o),
        .ireq_tdata_o  (ireq_tdata_o),
        .ireq_tkeep_o  (ireq_tkeep_o),
        .ireq_tuser_o  (ireq_tuser_o)
    );

    db_nwr_sequencer u_db_nwr_sequencer (
        .log_clk         (log_clk),
        .log_rst         (log_rst),
        .link_up_i       (link_up_i),
        .self_check_i    (self_check_i),
        .nwr_req_i       (nwr_req_i),
        .req_done_i      (req_done),
        .resp_ready_i    (resp_ready),
        .resp_busy_i     (resp_busy),
        .resp_confirm_i  (resp_confirm),
        .time_out_i      (time_out),
        .req_kind_o      (req_kind),
        .txn_id_o        (txn_id),
        .expected_info_o (expected_info),
        .wait_en_o       (wait_en),
        .nwr_ready_o     (nwr_ready_o),
        .nwr_busy_o      (nwr_busy_o),
        .nwr_done_ack_o  (nwr_done_ack_o),
        .error_o         (error_o),
        .error_type_o    (error_type_o)
    );

endmodule

// File: req_beat_builder.sv
/* One-beat output register on the request stream, held stable until tready.
   Expects req_kind_i to go through REQ_NONE between two requests. */
`timescale 1ns/1ps
module req_beat_builder (
    input  logic                           log_clk,
    input  logic                           log_rst,
    input  srio_db_pkg::req_kind_e         req_kind_i,
    input  logic                           txn_id_i,
    input  logic [15:0]                    src_id_i,
    input  logic [15:0]                    dest_id_i,
    input  logic                           head_valid_i,
    input  logic                           head_first_i,
    input  logic                           head_last_i,
    input  logic [srio_db_pkg::KEEP_W-1:0] head_keep_i,
    input  srio_db_pkg::beat_t             head_data_i,
    input  logic                           ireq_tready_i,
    output logic                           fifo_pop_o,
    output logic                           req_done_o,
    output logic                           ireq_tvalid_o,
    output logic                           ireq_tlast_o,
    output srio_db_pkg::beat_t             ireq_tdata_o,
    output logic [srio_db_pkg::KEEP_W-1:0] ireq_tkeep_o,
    output logic [srio_db_pkg::USER_W-1:0] ireq_tuser_o
);
    import srio_db_pkg::*;

    logic              last_loaded;
    logic              can_load;
    logic              load;
    logic              nxt_last;
    logic [KEEP_W-1:0] nxt_keep;
    beat_t             nxt_data;
    logic [ADDR_W-1:0] nwr_addr;

    // No new beat once the last one of the request is in the register
    assign can_load = (!ireq_tvalid_o || ireq_tready_i) && !last_loaded;
    assign nwr_addr = txn_id_i ? TARGET_ADDR_STRIDE : '0;

    always_comb begin
        load       = 1'b0;
        fifo_pop_o = 1'b0;
        nxt_last   = 1'b1;
        nxt_keep   = '1;
        nxt_data   = '0;
        case (req_kind_i)
            REQ_SELF_DB: begin
                load     = can_load;
                nxt_data = make_db_header(DB_INFO_SELF_CHECK);
            end
            REQ_INTEG_DB: begin
                load     = can_load;
                nxt_data = make_db_header(integ_db_info(txn_id_i));
            end
            REQ_NWR: begin
                load       = can_load && head_valid_i;
                fifo_pop_o = load;
                if (head_first_i) begin
                    // First entry carries the size byte, becomes the header
                    nxt_last = 1'b0;
                    nxt_data = make_nwr_header(txn_id_i, head_data_i[7:0], nwr_addr);
                end else begin
                    nxt_last = head_last_i;
                    nxt_keep = head_keep_i;
                    nxt_data = head_data_i;
                end
            end
            default: begin
                load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            ireq_tvalid_o <= 1'b0;
            last_loaded   <= 1'b0;
        end else begin
            if (load) begin
                ireq_tvalid_o <= 1'b1;
            end else if (ireq_tready_i) begin
                ireq_tvalid_o <= 1'b0;
            end
            if (req_kind_i == REQ_NONE) begin
                last_loaded <= 1'b0;
            end else if (load && nxt_last) begin
                last_loaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge log_clk) begin
        if (load) begin
            ireq_tlast_o <= nxt_last;
            ireq_tdata_o <= nxt_data;
            ireq_tkeep_o <= nxt_keep;
            ireq_tuser_o <= {src_id_i, dest_id_i};
        end
    end

    assign req_done_o = ireq_tvalid_o && ireq_tready_i && ireq_tlast_o;

endmodule

// File: resp_decoder.sv
/* Accepts only doorbell responses whose tuser source ID is RESP_SRC_ID.
   Pulses come one cycle after the beat; unknown info values are dropped. */
`timescale 1ns/1ps
module resp_decoder (
    input  logic                           log_clk,
    input  logic                           log_rst,
    input  logic                           iresp_tvalid_i,
    input  srio_db_pkg::beat_t             iresp_tdata_i,
    input  logic [srio_db_pkg::USER_W-1:0] iresp_tuser_i,
    input  logic [15:0]                    expected_info_i,
    output logic                           resp_ready_o,
    output logic                           resp_busy_o,
    output logic                           resp_confirm_o
);
    import srio_db_pkg::*;

    logic [3:0]  resp_ftype;
    logic [15:0] resp_info;
    logic [15:0] resp_src;
    logic        resp_hit;

    assign resp_ftype = iresp_tdata_i[55:52];
    assign resp_info  = iresp_tdata_i[31:16];
    // Source ID sits in the upper half of tuser
    assign resp_src   = iresp_tuser_i[USER_W-1:16];
    assign resp_hit   = iresp_tvalid_i && (resp_ftype == FTYPE_DOORBELL)
                        && (resp_src == RESP_SRC_ID);

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            resp_ready_o   <= 1'b0;
            resp_busy_o    <= 1'b0;
            resp_confirm_o <= 1'b0;
        end else begin
            resp_ready_o   <= resp_hit && (resp_info == DB_INFO_READY);
            resp_busy_o    <= resp_hit && (resp_info == DB_INFO_BUSY);
            resp_confirm_o <= resp_hit && (resp_info == expected_info_i);
        end
    end

endmodule

// File: resp_timer.sv
/* Pulses time_out_o after wait_en_i has been high for TIMEOUT_CYCLES cycles.
   Any low cycle on wait_en_i restarts the count. */
`timescale 1ns/1ps
module resp_timer (
    input  logic log_clk,
    input  logic log_rst,
    input  logic wait_en_i,
    output logic time_out_o
);
    import srio_db_pkg::*;

    logic [$clog2(TIMEOUT_CYCLES)-1:0] cnt;

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            cnt        <= '0;
            time_out_o <= 1'b0;
        end else if (wait_en_i) begin
            // Wraps to zero on the expiry cycle, so the pulse is single
            cnt        <= cnt + 1'b1;
            time_out_o <= (cnt == TIMEOUT_CYCLES - 1);
        end else begin
            cnt        <= '0;
            time_out_o <= 1'b0;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Verilator build and run of the doorbell/NWRITE initiator testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_db_req -f src.f
./obj_dir/Vtb_db_req | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// File: src.f
srio_db_pkg.sv
user_beat_fifo.sv
resp_decoder.sv
resp_timer.sv
req_beat_builder.sv
db_nwr_sequencer.sv
db_req_top.sv
db_req_assert.sv
tb_db_req.sv

// File: srio_db_pkg.sv
/* Field codes, widths and header builders for the doorbell/NWRITE initiator.
   Headers follow the 64-bit logical-layer request layout; only ftype 0xA and 0x5 are built. */
package srio_db_pkg;

    localparam int DATA_W     = 64;
    localparam int KEEP_W     = 8;
    localparam int ADDR_W     = 34;
    localparam int USER_W     = 32;
    localparam int FIFO_DEPTH = 512;

    localparam logic [3:0] FTYPE_DOORBELL = 4'hA;
    localparam logic [3:0] FTYPE_NWRITE   = 4'h5;
    localparam logic [3:0] TTYPE_NWRITE   = 4'h4;
    localparam logic [1:0] REQ_PRIO       = 2'd1;

    localparam logic [15:0] DB_INFO_SELF_CHECK = 16'h0101;
    localparam logic [15:0] DB_INFO_READY      = 16'h0100;
    localparam logic [15:0] DB_INFO_BUSY       = 16'h01FF;
    localparam logic [15:0] DB_INFO_INTEG_BASE = 16'h0200;

    localparam logic [15:0]       RESP_SRC_ID        = 16'h00F0;
    localparam logic [ADDR_W-1:0] TARGET_ADDR_STRIDE = 34'h0010_0000;
    localparam int                TIMEOUT_CYCLES     = 1024;

    typedef logic [DATA_W-1:0] beat_t;

    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_SELF_DB,
        REQ_NWR,
        REQ_INTEG_DB
    } req_kind_e;

    typedef enum logic [1:0] {
        ERR_NONE          = 2'd0,
        ERR_DB_NO_RESP    = 2'd1,
        ERR_INTEG_NO_RESP = 2'd2
    } err_type_e;

    // Doorbell with source TID 0 and zero ttype
    function automatic beat_t make_db_header(input logic [15:0] info);
        beat_t hdr;
        hdr          = '0;
        hdr[55:52]   = FTYPE_DOORBELL;
        hdr[46:45]   = REQ_PRIO;
        hdr[31:16]   = info;
        return hdr;
    endfunction

    function automatic beat_t make_nwr_header(input logic              tid,
                                              input logic [7:0]        size,
                                              input logic [ADDR_W-1:0] addr);
        beat_t hdr;
        hdr          = '0;
        hdr[63:56]   = {7'd0, tid};
        hdr[55:52]   = FTYPE_NWRITE;
        hdr[51:48]   = TTYPE_NWRITE;
        hdr[46:45]   = REQ_PRIO;
        hdr[43:36]   = size;
        hdr[33:0]    = addr;
        return hdr;
    endfunction

    // Integrity info is 0x0200 + n, n being the inverse of the TID bit
    function automatic logic [15:0] integ_db_info(input logic tid);
        return DB_INFO_INTEG_BASE + {15'd0, !tid};
    endfunction

endpackage

// File: tb_db_req.sv
/* Testbench for db_req_top with a target responder model and xorshift stimulus.
   Inputs change on the falling edge; a cycle watchdog bounds the run. */
`timescale 1ns/1ps
module tb_db_req;
    import srio_db_pkg::*;

    localparam logic [15:0] SRC_ID     = 16'h0011;
    localparam logic [15:0] DEST_ID    = 16'h00F0;
    // Seven transactions and two timer expiries, with margin
    localparam int          TXN_COUNT  = 7;
    localparam int          TXN_CYCLES = 200;
    localparam int          MAX_CYCLES = 16 + TXN_COUNT * TXN_CYCLES
                                         + 2 * (TIMEOUT_CYCLES + 16);

    logic              log_clk;
    logic              log_rst;
    logic              link_up_i;
    logic              self_check_i;
    logic              nwr_req_i;
    logic              user_tvalid_i;
    logic              user_tready_o;
    logic              user_tfirst_i;
    logic              user_tlast_i;
    logic [63:0]       user_tdata_i;
    logic [7:0]        user_tkeep_i;
    logic [7:0]        user_tsize_i;
    logic              ireq_tvalid_o;
    logic              ireq_tready_i;
    logic              ireq_tlast_o;
    logic [63:0]       ireq_tdata_o;
    logic [7:0]        ireq_tkeep_o;
    logic [31:0]       ireq_tuser_o;
    logic              iresp_tvalid_i;
    logic              iresp_tready_o;
    logic [63:0]       iresp_tdata_i;
    logic [31:0]       iresp_tuser_i;
    logic              nwr_ready_o;
    logic              nwr_busy_o;
    logic              nwr_done_ack_o;
    logic              error_o;
    err_type_e         error_type_o;

    logic [31:0]       rng_state;
    logic              model_tid;
    int                checks;
    int                errors;

    db_req_top u_db_req_top (
        .log_clk        (log_clk),
        .log_rst        (log_rst),
        .src_id_i       (SRC_ID),
        .dest_id_i      (DEST_ID),
        .link_up_i      (link_up_i),
        .self_check_i   (self_check_i),
        .nwr_req_i      (nwr_req_i),
        .user_tvalid_i  (user_tvalid_i),
        .user_tready_o  (user_tready_o),
        .user_tfirst_i  (user_tfirst_i),
        .user_tlast_i   (user_tlast_i),
        .user_tdata_i   (user_tdata_i),
        .user_tkeep_i   (user_tkeep_i),
        .user_tsize_i   (user_tsize_i),
        .ireq_tvalid_o  (ireq_tvalid_o),
        .ireq_tready_i  (ireq_tready_i),
        .ireq_tlast_o   (ireq_tlast_o),
        .ireq_tdata_o   (ireq_tdata_o),
        .ireq_tkeep_o   (ireq_tkeep_o),
        .ireq_tuser_o   (ireq_tuser_o),
        .iresp_tvalid_i (iresp_tvalid_i),
        .iresp_tready_o (iresp_tready_o),
        .iresp_tdata_i  (iresp_tdata_i),
        .iresp_tuser_i  (iresp_tuser_i),
        .nwr_ready_o    (nwr_ready_o),
        .nwr_busy_o     (nwr_busy_o),
        .nwr_done_ack_o (nwr_done_ack_o),
        .error_o        (error_o),
        .error_type_o   (error_type_o)
    );

    initial begin
        log_clk = 1'b0;
        forever #50 log_clk = ~log_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Waits for one accepted request beat, tready random at 75 percent
    task automatic take_beat(input string name, input logic [63:0] exp_data,
                             input logic [7:0] exp_keep, input logic exp_last);
        logic got;
        got = 1'b0;
        while (!got) begin
            @(negedge log_clk);
            ireq_tready_i = ((next_random() & 32'h3) != 0);
            got = ireq_tvalid_o && ireq_tready_i;
        end
        check_value({name, " data"}, exp_data, ireq_tdata_o);
        check_value({name, " keep"}, exp_keep, ireq_tkeep_o);
        check_value({name, " last"}, exp_last, ireq_tlast_o);
        check_value({name, " user"}, {SRC_ID, DEST_ID}, ireq_tuser_o);
    endtask

    // Target answer, status visible two edges later
    task automatic send_response(input logic [15:0] resp_id, input logic [15:0] info);
        logic [63:0] data;
        data        = 64'd0;
        data[55:52] = FTYPE_DOORBELL;
        data[31:16] = info;
        @(negedge log_clk);
        iresp_tvalid_i = 1'b1;
        iresp_tdata_i  = data;
        iresp_tuser_i  = {resp_id, SRC_ID};
        check_value("response tready", 1'b1, iresp_tready_o);
        @(negedge log_clk);
        iresp_tvalid_i = 1'b0;
        @(negedge log_clk);
    endtask

    task automatic run_self_check(input string name);
        @(negedge log_clk);
        self_check_i = 1'b1;
        @(negedge log_clk);
        self_check_i = 1'b0;
        take_beat(name, make_db_header(16'h0101), 8'hFF, 1'b1);
    endtask

    task automatic expect_timeout(input string name, input logic [1:0] exp_type);
        int cycles;
        cycles = 0;
        @(negedge log_clk);
        while (!error_o) begin
            cycles++;
            @(negedge log_clk);
        end
        check_value({name, " cycles"}, TIMEOUT_CYCLES + 1, cycles);
        check_value({name, " type"}, exp_type, error_type_o);
        check_value({name, " ready"}, 1'b0, nwr_ready_o);
        check_value({name, " busy"}, 1'b0, nwr_busy_o);
        @(negedge log_clk);
        check_value({name, " pulse end"}, 1'b0, error_o);
    endtask

    task automatic run_nwrite(input string name, input logic answer);
        int          n;
        int          r;
        int          i;
        logic [7:0]  size;
        logic [33:0] addr;
        logic [15:0] info;
        logic [63:0] data_q[$];
        logic [7:0]  keep_q[$];
        n    = 1 + int'(next_random() % 8);
        r    = int'(next_random() % 8);
        size = 8'((n - 1) * 8 + 7 - r);
        for (i = 0; i < n; i++) begin
            data_q.push_back({next_random(), next_random()});
            keep_q.push_back((i == n - 1) ? (8'hFF >> r) : 8'hFF);
        end
        // Size entry first, then the data beats
        @(negedge log_clk);
        user_tvalid_i = 1'b1;
        user_tfirst_i = 1'b1;
        user_tlast_i  = 1'b0;
        user_tsize_i  = size;
        user_tdata_i  = 64'd0;
        user_tkeep_i  = 8'hFF;
        while (!user_tready_o) @(negedge log_clk);
        for (i = 0; i < n; i++) begin
            @(negedge log_clk);
            user_tfirst_i = 1'b0;
            user_tlast_i  = (i == n - 1);
            user_tdata_i  = data_q[i];
            user_tkeep_i  = keep_q[i];
            while (!user_tready_o) @(negedge log_clk);
        end
        @(negedge log_clk);
        user_tvalid_i = 1'b0;
        user_tlast_i  = 1'b0;
        nwr_req_i     = 1'b1;
        @(negedge log_clk);
        nwr_req_i = 1'b0;
        // TID bit picks the 1 MiB window and the doorbell offset
        addr = model_tid ? 34'h10_0000 : 34'h0;
        info = 16'h0200 + {15'd0, !model_tid};
        take_beat({name, " header"}, make_nwr_header(model_tid, size, addr), 8'hFF, 1'b0);
        for (i = 0; i < n; i++) begin
            take_beat($sformatf("%s beat %0d", name, i), data_q[i], keep_q[i], i == n - 1);
        end
        take_beat({name, " integrity"}, make_db_header(info), 8'hFF, 1'b1);
        if (answer) begin
            send_response(RESP_SRC_ID, info);
            check_value({name, " done_ack"}, 1'b1, nwr_done_ack_o);
            model_tid = !model_tid;
        end else begin
            expect_timeout({name, " timeout"}, ERR_INTEG_NO_RESP);
        end
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge log_clk);
        $display("Testbench stopped after %0d cycles without finishing", MAX_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        rng_state      = 32'h461b_5adf;
        model_tid      = 1'b0;
        checks         = 0;
        errors         = 0;
        log_rst        = 1'b1;
        link_up_i      = 1'b1;
        self_check_i   = 1'b0;
        nwr_req_i      = 1'b0;
        user_tvalid_i  = 1'b0;
        user_tfirst_i  = 1'b0;
        user_tlast_i   = 1'b0;
        user_tdata_i   = 64'd0;
        user_tkeep_i   = 8'd0;
        user_tsize_i   = 8'd0;
        ireq_tready_i  = 1'b0;
        iresp_tvalid_i = 1'b0;
        iresp_tdata_i  = 64'd0;
        iresp_tuser_i  = 32'd0;
        repeat (3) @(posedge log_clk);
        @(negedge log_clk);
        log_rst = 1'b0;

        // Self-check answered READY
        run_self_check("self_check");
        send_response(RESP_SRC_ID, DB_INFO_READY);
        check_value("ready after READY", 1'b1, nwr_ready_o);
        check_value("busy after READY", 1'b0, nwr_busy_o);

        // Foreign ID and unknown info are ignored, then BUSY
        run_self_check("busy_check");
        check_value("ready cleared", 1'b0, nwr_ready_o);
        send_response(16'h00F1, DB_INFO_READY);
        check_value("foreign id ready", 1'b0, nwr_ready_o);
        send_response(RESP_SRC_ID, 16'h0123);
        check_value("unknown info ready", 1'b0, nwr_ready_o);
        check_value("unknown info busy", 1'b0, nwr_busy_o);
        send_response(RESP_SRC_ID, DB_INFO_BUSY);
        check_value("busy after BUSY", 1'b1, nwr_busy_o);
        check_value("ready after BUSY", 1'b0, nwr_ready_o);

        run_nwrite("nwrite_tid0", 1'b1);
        run_nwrite("nwrite_tid1", 1'b1);

        // Silent target
        run_self_check("silent_self_check");
        expect_timeout("self_check timeout", ERR_DB_NO_RESP);
        run_nwrite("silent_nwrite", 1'b0);
        run_nwrite("nwrite_after_timeout", 1'b1);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: user_beat_fifo.sv
/* Show-ahead FIFO: the head entry is visible combinationally whenever head_valid_o is high.
   wr_ready_o is registered and stays low for the first cycle after reset. */
`timescale 1ns/1ps
module user_beat_fifo (
    input  logic                           log_clk,
    input  logic                           log_rst,
    input  logic                           wr_valid_i,
    input  logic                           wr_first_i,
    input  logic                           wr_last_i,
    input  logic [srio_db_pkg::KEEP_W-1:0] wr_keep_i,
    input  srio_db_pkg::beat_t             wr_data_i,
    input  logic                           pop_i,
    output logic                           wr_ready_o,
    output logic                           head_valid_o,
    output logic                           head_first_o,
    output logic                           head_last_o,
    output logic [srio_db_pkg::KEEP_W-1:0] head_keep_o,
    output srio_db_pkg::beat_t             head_data_o
);
    import srio_db_pkg::*;

    // Entry layout is {first, last, keep, data}
    logic [DATA_W+KEEP_W+1:0]          mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]     wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]     rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0]   count;
    logic [$clog2(FIFO_DEPTH+1)-1:0]   count_nxt;
    logic                              push;
    logic                              pop;

    assign push = wr_valid_i && wr_ready_o;
    assign pop  = pop_i && head_valid_o;

    always_comb begin
        count_nxt = count;
        if (push && !pop) begin
            count_nxt = count + 1'b1;
        end else if (pop && !push) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge log_clk or posedge log_rst) begin
        if (log_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            wr_ready_o <= 1'b0;
        end else begin
            // Depth is a power of two, pointers wrap on their own
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count      <= count_nxt;
            wr_ready_o <= (count_nxt != FIFO_DEPTH);
        end
    end

    always_ff @(posedge log_clk) begin
        if (push) begin
            mem[wr_ptr] <= {wr_first_i, wr_last_i, wr_keep_i, wr_data_i};
        end
    end

    assign head_valid_o = (count != 0);
    assign {head_first_o, head_last_o, head_keep_o, head_data_o} = mem[rd_ptr];

endmodule
